/* include/core_mem_macros.svh */
// Width and size constants of the core memory region
// core and host word widths, byte enables, RAM sizes in bytes
// and the address prefix that selects the local data RAM

`ifndef CORE_MEM_MACROS_SVH
`define CORE_MEM_MACROS_SVH

// core side word
`define CORE_DATA_W 32
`define CORE_BE_W 4

// host side and RAM word
`define HOST_DATA_W 64
`define HOST_BE_W 8

// core and external bus address
`define BUS_ADDR_W 32

// RAM sizes in bytes
`define INSTR_RAM_BYTES 16384
`define DATA_RAM_BYTES 32768

// upper twelve address bits of the local data region
`define LOCAL_PREFIX 12'h001
`define PREFIX_LSB 20

`endif

/* rtl/mem_map_pkg.sv */
// Memory map types of the core memory region
// byte address types of instruction and data RAM
// and the source of a pending load/store response

`include "core_mem_macros.svh"

package mem_map_pkg;

  // byte address widths inside each RAM
  localparam int INSTR_ADDR_W = $clog2(`INSTR_RAM_BYTES);
  localparam int DATA_ADDR_W  = $clog2(`DATA_RAM_BYTES);

  // 14 bits, 16 KiB
  typedef logic [INSTR_ADDR_W-1:0] instr_addr_t;

  // 15 bits, 32 KiB
  typedef logic [DATA_ADDR_W-1:0] data_addr_t;

  // which side answers the last granted load/store
  typedef enum logic [0:0] {
    SRC_EXT = 1'b0,
    SRC_RAM = 1'b1
  } lsu_src_e;

endpackage

/* rtl/mem_bus_pkg.sv */
// Bus structs of the core memory region
// core request and response, host strobes for both RAMs
// and the response of the external bus

`include "core_mem_macros.svh"

package mem_bus_pkg;

  typedef logic [`BUS_ADDR_W-1:0]  bus_addr_t;
  typedef logic [`CORE_DATA_W-1:0] core_word_t;
  typedef logic [`CORE_BE_W-1:0]   core_be_t;
  typedef logic [`HOST_DATA_W-1:0] host_word_t;
  typedef logic [`HOST_BE_W-1:0]   host_be_t;

  // core load/store or fetch request, also used towards the external bus
  typedef struct packed {
    logic       req;
    bus_addr_t  addr;
    logic       we;
    core_be_t   be;
    core_word_t wdata;
  } core_req_t;

  typedef struct packed {
    logic       gnt;
    logic       rvalid;
    core_word_t rdata;
  } core_rsp_t;

  // host strobes, only the address field differs
  typedef struct packed {
    logic                     req;
    mem_map_pkg::instr_addr_t addr;
    logic                     we;
    host_be_t                 be;
    host_word_t               wdata;
  } instr_host_req_t;

  typedef struct packed {
    logic                    req;
    mem_map_pkg::data_addr_t addr;
    logic                    we;
    host_be_t                be;
    host_word_t              wdata;
  } data_host_req_t;

  typedef struct packed {
    logic       gnt;
    logic       rvalid;
    core_word_t rdata;
  } ext_rsp_t;

endpackage

/* rtl/sp_ram.sv */
// Single-port RAM with 64-bit words
// byte enable writes and one cycle registered read

`timescale 1ns/100ps

`include "core_mem_macros.svh"

module sp_ram #(
  parameter int WORDS = 4096
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     en_i,
  input  logic                     we_i,
  input  logic [$clog2(WORDS)-1:0] idx_i,
  input  mem_bus_pkg::host_be_t    be_i,
  input  mem_bus_pkg::host_word_t  wdata_i,
  output mem_bus_pkg::host_word_t  rdata_o
);

  import mem_bus_pkg::*;

  host_word_t mem [WORDS];
  host_word_t rdata_q;

  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        // only the enabled byte lanes change
        for (int b = 0; b < `HOST_BE_W; b++) begin
          if (be_i[b]) begin
            mem[idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem[idx_i];
      end
    end
  end

  assign rdata_o = rdata_q;

  // word index must stay inside the array
  idx_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    en_i |-> (int'(idx_i) < WORDS)
  ) else $error("sp_ram index %0d out of range", idx_i);

endmodule

/* rtl/ram_mux.sv */
// Port multiplexer for one single-port RAM
// 64-bit host strobe with fixed priority over a 32-bit core port,
// lane steering of core writes and one cycle core response

`timescale 1ns/100ps

`include "core_mem_macros.svh"

module ram_mux #(
  parameter type addr_t     = mem_map_pkg::data_addr_t,
  parameter type host_req_t = mem_bus_pkg::data_host_req_t,
  parameter bit  CORE_WRITES = 1'b1
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  host_req_t               host_req_i,
  output mem_bus_pkg::host_word_t host_rdata_o,
  input  mem_bus_pkg::core_req_t  core_req_i,
  output mem_bus_pkg::core_rsp_t  core_rsp_o
);

  import mem_bus_pkg::*;

  localparam int ADDR_W   = $bits(addr_t);
  // byte offset bits of a 64-bit word
  localparam int LANE_LSB = $clog2(`HOST_BE_W);
  // address bit that picks the upper 32-bit half
  localparam int HALF_BIT = $clog2(`CORE_BE_W);
  localparam int IDX_W    = ADDR_W - LANE_LSB;

  addr_t             core_addr;
  logic              core_gnt;
  logic              core_we;
  logic              core_hi_q;
  logic              core_rvalid_q;

  logic              ram_en;
  logic              ram_we;
  logic [IDX_W-1:0]  ram_idx;
  host_be_t          ram_be;
  host_word_t        ram_wdata;
  host_word_t        ram_rdata;

  assign core_addr = core_req_i.addr[ADDR_W-1:0];
  assign core_gnt  = core_req_i.req & ~host_req_i.req;
  // instruction side never takes core writes
  assign core_we   = CORE_WRITES & core_req_i.we;

  always_comb begin
    ram_en = host_req_i.req | core_req_i.req;
    if (host_req_i.req) begin
      ram_idx   = host_req_i.addr[ADDR_W-1:LANE_LSB];
      ram_we    = host_req_i.we;
      ram_be    = host_req_i.be;
      ram_wdata = host_req_i.wdata;
    end else begin
      ram_idx   = core_addr[ADDR_W-1:LANE_LSB];
      ram_we    = core_we;
      ram_wdata = {2{core_req_i.wdata}};
      if (core_addr[HALF_BIT]) begin
        ram_be = {core_req_i.be, {`CORE_BE_W{1'b0}}};
      end else begin
        ram_be = {{`CORE_BE_W{1'b0}}, core_req_i.be};
      end
    end
  end

  // remember the grant and the addressed half for the response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_rvalid_q <= 1'b0;
      core_hi_q     <= 1'b0;
    end else begin
      core_rvalid_q <= core_gnt;
      if (core_gnt) begin
        core_hi_q <= core_addr[HALF_BIT];
      end
    end
  end

  sp_ram #(
    .WORDS (2**IDX_W)
  ) ram_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .en_i    (ram_en),
    .we_i    (ram_we),
    .idx_i   (ram_idx),
    .be_i    (ram_be),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

  assign host_rdata_o      = ram_rdata;
  assign core_rsp_o.gnt    = core_gnt;
  assign core_rsp_o.rvalid = core_rvalid_q;
  assign core_rsp_o.rdata  = core_hi_q ? ram_rdata[`HOST_DATA_W-1:`CORE_DATA_W]
                                       : ram_rdata[`CORE_DATA_W-1:0];

  // host strobe always wins the RAM
  no_gnt_on_host: assert property (
    @(posedge clk) disable iff (!rst_n)
    host_req_i.req |-> !core_rsp_o.gnt
  ) else $error("core granted during host strobe");

  // one response per grant, exactly one cycle later
  rvalid_after_gnt: assert property (
    @(posedge clk) disable iff (!rst_n)
    core_rsp_o.rvalid |-> $past(core_rsp_o.gnt)
  ) else $error("core rvalid without grant in previous cycle");

endmodule

/* rtl/lsu_demux.sv */
// Load/store address decode
// local prefix goes to the data RAM, everything else to the external bus,
// responses are routed back by the side of the last granted request

`timescale 1ns/100ps

`include "core_mem_macros.svh"

module lsu_demux (
  input  logic                   clk,
  input  logic                   rst_n,
  input  mem_bus_pkg::core_req_t lsu_req_i,
  output mem_bus_pkg::core_rsp_t lsu_rsp_o,
  output mem_bus_pkg::core_req_t ram_req_o,
  input  mem_bus_pkg::core_rsp_t ram_rsp_i,
  output mem_bus_pkg::core_req_t ext_req_o,
  input  mem_bus_pkg::ext_rsp_t  ext_rsp_i
);

  import mem_map_pkg::*;

  logic     is_local;
  logic     lsu_gnt;
  lsu_src_e src_q;

  assign is_local = (lsu_req_i.addr[`BUS_ADDR_W-1:`PREFIX_LSB] == `LOCAL_PREFIX);

  // same payload on both sides, only one req may rise
  always_comb begin
    ram_req_o     = lsu_req_i;
    ram_req_o.req = lsu_req_i.req & is_local;
    ext_req_o     = lsu_req_i;
    ext_req_o.req = lsu_req_i.req & ~is_local;
  end

  always_comb begin
    lsu_gnt = 1'b0;
    if (ram_req_o.req) begin
      lsu_gnt = ram_rsp_i.gnt;
    end else if (ext_req_o.req) begin
      lsu_gnt = ext_rsp_i.gnt;
    end
  end

  // side that will deliver the next rvalid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      src_q <= SRC_RAM;
    end else if (lsu_req_i.req && lsu_gnt) begin
      src_q <= is_local ? SRC_RAM : SRC_EXT;
    end
  end

  assign lsu_rsp_o.gnt    = lsu_gnt;
  assign lsu_rsp_o.rvalid = ram_rsp_i.rvalid | ext_rsp_i.rvalid;
  assign lsu_rsp_o.rdata  = (src_q == SRC_EXT) ? ext_rsp_i.rdata : ram_rsp_i.rdata;

  one_side_only: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(ram_req_o.req && ext_req_o.req)
  ) else $error("load/store sent to data RAM and external bus at once");

endmodule

/* rtl/core_mem_region.sv */
// Memory side of the core region
// load/store demux, instruction RAM and data RAM, each behind
// a host/core port multiplexer

`timescale 1ns/100ps

module core_mem_region (
  input  logic                         clk,
  input  logic                         rst_n,

  // core fetch and load/store ports
  input  mem_bus_pkg::core_req_t       fetch_req_i,
  output mem_bus_pkg::core_rsp_t       fetch_rsp_o,
  input  mem_bus_pkg::core_req_t       lsu_req_i,
  output mem_bus_pkg::core_rsp_t       lsu_rsp_o,

  // external bus
  output mem_bus_pkg::core_req_t       ext_req_o,
  input  mem_bus_pkg::ext_rsp_t        ext_rsp_i,

  // host strobes into both RAMs
  input  mem_bus_pkg::instr_host_req_t instr_host_req_i,
  output mem_bus_pkg::host_word_t      instr_host_rdata_o,
  input  mem_bus_pkg::data_host_req_t  data_host_req_i,
  output mem_bus_pkg::host_word_t      data_host_rdata_o
);

  // local load/store path between demux and data RAM
  mem_bus_pkg::core_req_t data_ram_req;
  mem_bus_pkg::core_rsp_t data_ram_rsp;

  lsu_demux lsu_demux_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .lsu_req_i (lsu_req_i),
    .lsu_rsp_o (lsu_rsp_o),
    .ram_req_o (data_ram_req),
    .ram_rsp_i (data_ram_rsp),
    .ext_req_o (ext_req_o),
    .ext_rsp_i (ext_rsp_i)
  );

  // instruction RAM, 16 KiB, fetches are read only
  ram_mux #(
    .addr_t      (mem_map_pkg::instr_addr_t),
    .host_req_t  (mem_bus_pkg::instr_host_req_t),
    .CORE_WRITES (1'b0)
  ) instr_ram_mux (
    .clk          (clk),
    .rst_n        (rst_n),
    .host_req_i   (instr_host_req_i),
    .host_rdata_o (instr_host_rdata_o),
    .core_req_i   (fetch_req_i),
    .core_rsp_o   (fetch_rsp_o)
  );

  // data RAM, 32 KiB
  ram_mux #(
    .addr_t      (mem_map_pkg::data_addr_t),
    .host_req_t  (mem_bus_pkg::data_host_req_t),
    .CORE_WRITES (1'b1)
  ) data_ram_mux (
    .clk          (clk),
    .rst_n        (rst_n),
    .host_req_i   (data_host_req_i),
    .host_rdata_o (data_host_rdata_o),
    .core_req_i   (data_ram_req),
    .core_rsp_o   (data_ram_rsp)
  );

endmodule

/* test/tb_core_mem_region.sv */
// Testbench of the core memory region
// clock, reset, host and core stimulus, byte models of both RAMs,
// external bus responder, concurrent checks and watchdog

`timescale 1ns/100ps

`include "core_mem_macros.svh"

module tb_core_mem_region;

  import mem_bus_pkg::*;
  import mem_map_pkg::*;

  localparam int NUM_OPS = 400;
  localparam int WIN     = 32;

  logic clk;
  logic rst_n;
  core_req_t       fetch_req;
  core_rsp_t       fetch_rsp;
  core_req_t       lsu_req;
  core_rsp_t       lsu_rsp;
  core_req_t       ext_req;
  ext_rsp_t        ext_rsp;
  instr_host_req_t instr_host_req;
  logic [63:0]     instr_host_rdata;
  data_host_req_t  data_host_req;
  logic [63:0]     data_host_rdata;

  // byte models and expected values seen by the assertions
  logic [7:0]  data_mem [`DATA_RAM_BYTES];
  logic [7:0]  instr_mem [`INSTR_RAM_BYTES];
  logic [31:0] lsu_exp;
  logic        lsu_chk;
  logic [31:0] fetch_exp;
  logic [63:0] data_host_exp;
  logic [63:0] instr_host_exp;
  logic        idle_chk;

  core_mem_region core_mem_region_inst (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_req_i        (fetch_req),
    .fetch_rsp_o        (fetch_rsp),
    .lsu_req_i          (lsu_req),
    .lsu_rsp_o          (lsu_rsp),
    .ext_req_o          (ext_req),
    .ext_rsp_i          (ext_rsp),
    .instr_host_req_i   (instr_host_req),
    .instr_host_rdata_o (instr_host_rdata),
    .data_host_req_i    (data_host_req),
    .data_host_rdata_o  (data_host_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic report_fail(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first failed check");
  endtask

  function automatic logic is_local(input logic [31:0] addr);
    return addr[31:20] == 12'h001;
  endfunction

  // external slave answers with a fixed pattern of the address
  function automatic logic [31:0] ext_data(input logic [31:0] addr);
    return {addr[15:0] ^ 16'hc3a5, ~addr[31:16]};
  endfunction

  function automatic logic [63:0] data_word(input int idx);
    logic [63:0] w;
    for (int b = 0; b < 8; b++) w[b*8 +: 8] = data_mem[idx*8 + b];
    return w;
  endfunction

  function automatic logic [63:0] instr_word(input int idx);
    logic [63:0] w;
    for (int b = 0; b < 8; b++) w[b*8 +: 8] = instr_mem[idx*8 + b];
    return w;
  endfunction

  // checks on the DUT outputs
  idle_after_reset: assert property (@(posedge clk)
    idle_chk |-> !lsu_rsp.rvalid && !fetch_rsp.rvalid && !ext_req.req)
    else report_fail("response or external request while idle after reset");

  local_load_data: assert property (@(posedge clk) disable iff (!rst_n)
    lsu_req.req && lsu_rsp.gnt && is_local(lsu_req.addr) |=> lsu_rsp.rvalid)
    else report_fail("local load/store rvalid missing one cycle after grant");

  lsu_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    lsu_rsp.rvalid && lsu_chk |-> lsu_rsp.rdata == lsu_exp)
    else report_fail($sformatf("lsu rdata %h, expected %h", lsu_rsp.rdata, lsu_exp));

  ext_forward: assert property (@(posedge clk) disable iff (!rst_n)
    ext_req.req == (lsu_req.req && !is_local(lsu_req.addr)) &&
    (!ext_req.req || (ext_req.addr == lsu_req.addr && ext_req.we == lsu_req.we &&
                      ext_req.be == lsu_req.be && ext_req.wdata == lsu_req.wdata)))
    else report_fail("external request differs from load/store request");

  ext_gnt_follow: assert property (@(posedge clk) disable iff (!rst_n)
    ext_req.req |-> lsu_rsp.gnt == ext_rsp.gnt)
    else report_fail("core grant does not follow external grant");

  host_wins_data: assert property (@(posedge clk) disable iff (!rst_n)
    data_host_req.req && lsu_req.req && is_local(lsu_req.addr) |-> !lsu_rsp.gnt)
    else report_fail("load/store granted during data host strobe");

  host_wins_instr: assert property (@(posedge clk) disable iff (!rst_n)
    instr_host_req.req |-> !fetch_rsp.gnt)
    else report_fail("fetch granted during instruction host strobe");

  fetch_data: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_req.req && fetch_rsp.gnt |=> fetch_rsp.rvalid && fetch_rsp.rdata == fetch_exp)
    else report_fail($sformatf("fetch rdata %h, expected %h", fetch_rsp.rdata, fetch_exp));

  data_host_read: assert property (@(posedge clk) disable iff (!rst_n)
    data_host_req.req && !data_host_req.we |=> data_host_rdata == data_host_exp)
    else report_fail($sformatf("data host rdata %h, expected %h",
                               data_host_rdata, data_host_exp));

  instr_host_read: assert property (@(posedge clk) disable iff (!rst_n)
    instr_host_req.req && !instr_host_req.we |=> instr_host_rdata == instr_host_exp)
    else report_fail($sformatf("instr host rdata %h, expected %h",
                               instr_host_rdata, instr_host_exp));

  // external slave grants after 0 to 3 cycles and answers 1 to 4 cycles later
  initial begin
    logic [31:0] addr;
    int unsigned wait_cyc;
    forever begin
      @(posedge clk);
      if (rst_n && ext_req.req) begin
        addr     = ext_req.addr;
        wait_cyc = $urandom_range(3, 0);
        repeat (wait_cyc) @(negedge clk);
        @(negedge clk);
        ext_rsp.gnt = 1'b1;
        @(negedge clk);
        ext_rsp.gnt = 1'b0;
        wait_cyc = $urandom_range(4, 1);
        repeat (wait_cyc - 1) @(negedge clk);
        ext_rsp.rvalid = 1'b1;
        ext_rsp.rdata  = ext_data(addr);
        @(negedge clk);
        ext_rsp.rvalid = 1'b0;
      end
    end
  end

  task automatic host_write_data(input int idx, input logic [7:0] be, input logic [63:0] wd);
    @(negedge clk);
    data_host_req = '{req: 1'b1, addr: data_addr_t'(idx * 8), we: 1'b1, be: be, wdata: wd};
    for (int b = 0; b < 8; b++) begin
      if (be[b]) data_mem[idx*8 + b] = wd[b*8 +: 8];
    end
    @(negedge clk);
    data_host_req.req = 1'b0;
  endtask

  task automatic host_read_data(input int idx);
    @(negedge clk);
    data_host_exp = data_word(idx);
    data_host_req = '{req: 1'b1, addr: data_addr_t'(idx * 8 + 5), we: 1'b0, be: '0, wdata: '0};
    @(negedge clk);
    data_host_req.req = 1'b0;
  endtask

  task automatic host_write_instr(input int idx, input logic [63:0] wd);
    @(negedge clk);
    instr_host_req = '{req: 1'b1, addr: instr_addr_t'(idx * 8), we: 1'b1, be: 8'hff, wdata: wd};
    for (int b = 0; b < 8; b++) instr_mem[idx*8 + b] = wd[b*8 +: 8];
    @(negedge clk);
    instr_host_req.req = 1'b0;
  endtask

  task automatic host_read_instr(input int idx);
    @(negedge clk);
    instr_host_exp = instr_word(idx);
    instr_host_req = '{req: 1'b1, addr: instr_addr_t'(idx * 8), we: 1'b0, be: '0, wdata: '0};
    @(negedge clk);
    instr_host_req.req = 1'b0;
  endtask

  // wait for grant and response of the driven request
  task automatic finish_lsu();
    #1;
    while (!lsu_rsp.gnt) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    lsu_req.req = 1'b0;
    #1;
    while (!lsu_rsp.rvalid) begin
      @(negedge clk);
      #1;
    end
    @(posedge clk);
  endtask

  task automatic set_lsu(input logic [31:0] addr, input logic we, input logic [3:0] be,
                         input logic [31:0] wd);
    int base;
    base = int'(addr[14:0]) & ~3;
    lsu_chk = !we;
    if (is_local(addr)) begin
      for (int b = 0; b < 4; b++) lsu_exp[b*8 +: 8] = data_mem[base + b];
      if (we) begin
        for (int b = 0; b < 4; b++) begin
          if (be[b]) data_mem[base + b] = wd[b*8 +: 8];
        end
      end
    end else begin
      lsu_exp = ext_data(addr);
    end
    lsu_req = '{req: 1'b1, addr: addr, we: we, be: be, wdata: wd};
  endtask

  task automatic lsu_access(input logic [31:0] addr, input logic we, input logic [3:0] be,
                            input logic [31:0] wd);
    @(negedge clk);
    set_lsu(addr, we, be, wd);
    finish_lsu();
  endtask

  task automatic set_fetch(input int idx, input logic hi, input logic we);
    int base;
    base = idx * 8 + (hi ? 4 : 0);
    for (int b = 0; b < 4; b++) fetch_exp[b*8 +: 8] = instr_mem[base + b];
    fetch_req = '{req: 1'b1, addr: 32'(base), we: we, be: 4'hf, wdata: $urandom};
  endtask

  // wait for the grant of the driven fetch
  task automatic finish_fetch();
    #1;
    while (!fetch_rsp.gnt) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    fetch_req.req = 1'b0;
    @(posedge clk);
  endtask

  task automatic fetch_access(input int idx, input logic hi, input logic we);
    @(negedge clk);
    set_fetch(idx, hi, we);
    finish_fetch();
  endtask

  function automatic logic [31:0] local_addr();
    return 32'h0010_0000 | ($urandom_range(WIN - 1, 0) << 3) | ($urandom_range(1, 0) << 2);
  endfunction

  function automatic logic [31:0] remote_addr();
    logic [31:0] a;
    a = $urandom;
    if (is_local(a)) a[31] = 1'b1;
    return a;
  endfunction

  initial begin
    void'($urandom(32'hf5ea123b));
    rst_n          = 1'b0;
    idle_chk       = 1'b0;
    lsu_chk        = 1'b0;
    lsu_exp        = '0;
    fetch_exp      = '0;
    data_host_exp  = '0;
    instr_host_exp = '0;
    fetch_req      = '0;
    lsu_req        = '0;
    ext_rsp        = '0;
    instr_host_req = '0;
    data_host_req  = '0;
    repeat (3) @(negedge clk);
    rst_n    = 1'b1;
    idle_chk = 1'b1;
    repeat (4) @(negedge clk);
    idle_chk = 1'b0;

    // preload both windows with full words
    for (int i = 0; i < WIN; i++) host_write_data(i, 8'hff, {$urandom, $urandom});
    for (int i = 0; i < WIN; i++) host_write_instr(i, {$urandom, $urandom});

    // host writes with random byte enables and local loads
    for (int i = 0; i < 40; i++) begin
      host_write_data($urandom_range(WIN - 1, 0), 8'($urandom), {$urandom, $urandom});
      lsu_access(local_addr(), 1'b0, 4'hf, '0);
    end

    // core stores merge into words that the host reads back
    for (int i = 0; i < 40; i++) begin
      logic [31:0] a;
      a = local_addr();
      lsu_access(a, 1'b1, 4'($urandom), $urandom);
      host_read_data(int'(a[14:3]));
    end

    // external loads and stores and then alternating sides
    for (int i = 0; i < 30; i++) lsu_access(remote_addr(), 1'($urandom), 4'hf, $urandom);
    for (int i = 0; i < 30; i++) begin
      lsu_access(local_addr(), 1'b0, 4'hf, '0);
      lsu_access(remote_addr(), 1'b0, 4'hf, '0);
    end

    // host strobe and local load in the same cycle
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      data_host_exp = data_word(3);
      data_host_req = '{req: 1'b1, addr: data_addr_t'(24), we: 1'b0, be: '0, wdata: '0};
      set_lsu(local_addr(), 1'b0, 4'hf, '0);
      @(negedge clk);
      data_host_req.req = 1'b0;
      finish_lsu();
    end

    // plain fetches
    for (int i = 0; i < 30; i++) fetch_access($urandom_range(WIN - 1, 0), 1'($urandom), 1'b0);

    // instruction host strobe and fetch in the same cycle
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      instr_host_exp = instr_word(5);
      instr_host_req = '{req: 1'b1, addr: instr_addr_t'(40), we: 1'b0, be: '0, wdata: '0};
      set_fetch($urandom_range(WIN - 1, 0), 1'($urandom), 1'b0);
      @(negedge clk);
      instr_host_req.req = 1'b0;
      finish_fetch();
    end

    // fetches with we high leave the RAM untouched
    for (int i = 0; i < 10; i++) begin
      int idx;
      idx = $urandom_range(WIN - 1, 0);
      fetch_access(idx, 1'($urandom), 1'b1);
      host_read_instr(idx);
    end

    repeat (4) @(negedge clk);
    $display("PASS: all tests");
    $finish;
  end

  // watchdog
  initial begin
    repeat (NUM_OPS * 10 + 200) @(posedge clk);
    $display("watchdog expired before all tests completed");
    $display("FAIL: see errors above");
    $fatal(1, "timeout");
  end

endmodule

/* core_mem_region.f */
+incdir+include
rtl/mem_map_pkg.sv
rtl/mem_bus_pkg.sv
rtl/sp_ram.sv
rtl/ram_mux.sv
rtl/lsu_demux.sv
rtl/core_mem_region.sv
test/tb_core_mem_region.sv

/* run.sh */
#!/bin/sh
# build and run the core_mem_region testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f core_mem_region.f \
  --top-module tb_core_mem_region \
  -o sim_tb_core_mem_region
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/sim_tb_core_mem_region)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "PASS: all tests"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
